// ==== src/fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

  localparam int addr_w       = 64;
  localparam int instr_w      = 32;
  localparam int bus_data_w   = 64;
  localparam int bus_tag_w    = 13;
  localparam int page_bits    = 12;
  localparam int line_bytes   = 32;
  localparam int icache_lines = 64;
  localparam int tlb_entries  = 4;

  localparam int vpn_w          = addr_w - page_bits;         // Also the PPN width
  localparam int tlb_idx_w      = $clog2(tlb_entries);
  localparam int beats_per_line = line_bytes * 8 / bus_data_w;
  localparam int beat_sel_w     = $clog2(beats_per_line);
  localparam int byte_off_w     = $clog2(bus_data_w / 8);    // Byte offset within a beat
  localparam int line_off_w     = $clog2(line_bytes);
  localparam int index_w        = $clog2(icache_lines);
  localparam int ctag_w         = addr_w - index_w - line_off_w;
  localparam logic [beat_sel_w-1:0] last_beat = beat_sel_w'(beats_per_line - 1);

  // Memory contents and page table are generated, not stored
  localparam logic [vpn_w-1:0]   ppn_xor   = 52'h00000_0001_2345;
  localparam logic [instr_w-1:0] instr_xor = 32'h1357_9bdf;

  typedef enum logic [bus_tag_w-1:0] {
    tag_tlb    = 13'd1,
    tag_icache = 13'd2
  } bus_tag_e;

  typedef struct packed {
    logic [addr_w-1:0] addr;
    bus_tag_e          tag;
  } bus_req_t;

  typedef struct packed {
    logic [bus_data_w-1:0] data;
    bus_tag_e              tag;
  } bus_resp_t;

  typedef enum logic [1:0] {sel_seq, sel_branch, sel_flush} pc_sel_e;

  typedef struct packed {
    logic [addr_w-1:0] va;
    logic              rd;
  } xlate_t;

  typedef struct packed {
    logic [addr_w-1:0]  pcplus4;
    logic [instr_w-1:0] instr;
  } fetch_out_t;

  // PTE layout: physical page number in the upper bits, low bits zero
  function automatic logic [bus_data_w-1:0] pte_of(input logic [vpn_w-1:0] vpn);
    return {vpn ^ ppn_xor, {page_bits{1'b0}}};
  endfunction

  function automatic logic [addr_w-1:0] xlate_pa(input logic [addr_w-1:0] va);
    return {va[addr_w-1:page_bits] ^ ppn_xor, va[page_bits-1:0]};
  endfunction

  function automatic logic [instr_w-1:0] mem_word(input logic [addr_w-1:0] pa);
    return pa[instr_w-1:0] ^ instr_xor;
  endfunction

  function automatic logic [bus_data_w-1:0] mem_beat(input logic [addr_w-1:0] pa);
    logic [addr_w-1:0] base;
    base = {pa[addr_w-1:byte_off_w], {byte_off_w{1'b0}}};
    return {mem_word(base + 64'd4), mem_word(base)};  // Little endian halves
  endfunction

endpackage

`default_nettype wire

// ==== src/fetch.sv ====
`timescale 1ns/10ps
`default_nettype none

module fetch (
  input  logic                  clk,
  input  logic                  reset,
  input  logic [63:0]           entry,
  input  logic                  branch_taken,
  input  logic [63:0]           target,
  input  logic                  enable,
  input  logic                  syscall_flush,
  input  logic [63:0]           sys_call_addrplus1,
  output fetch_pkg::xlate_t     xlate,
  input  logic                  pa_valid,
  output logic                  cache_rd,
  input  logic [31:0]           instr_bits,
  input  logic                  data_valid,
  output fetch_pkg::fetch_out_t out,
  output logic                  out_valid
);

  fetch_pkg::pc_sel_e pc_sel;
  logic [63:0]        old_pc;
  logic [63:0]        pc;
  logic               deliver;

  // Flush beats branch beats sequential
  always_comb begin
    if (syscall_flush)
      pc_sel = fetch_pkg::sel_flush;
    else if (branch_taken)
      pc_sel = fetch_pkg::sel_branch;
    else
      pc_sel = fetch_pkg::sel_seq;
  end

  always_comb begin
    case (pc_sel)
      fetch_pkg::sel_flush:  pc = sys_call_addrplus1 - 64'd4;
      fetch_pkg::sel_branch: pc = target;
      default:               pc = old_pc + 64'd4;
    endcase
  end

  assign xlate.va = pc;
  assign xlate.rd = !syscall_flush;   // Cancel any lookup on flush
  assign cache_rd = !syscall_flush;

  assign deliver = pa_valid && data_valid && enable && !syscall_flush;

  always_ff @(posedge clk) begin
    if (reset) begin
      old_pc    <= entry - 64'd4;    // First sequential PC is entry
      out       <= '0;
      out_valid <= 1'b0;
    end else if (syscall_flush) begin
      old_pc    <= pc - 64'd4;       // Refetch from sys_call_addrplus1 - 4
      out       <= '0;
      out_valid <= 1'b0;
    end else if (deliver) begin
      old_pc      <= pc;
      out.pcplus4 <= pc + 64'd4;
      out.instr   <= instr_bits;
      out_valid   <= 1'b1;
    end else begin
      // Stalled or held by decode
      // a branch seen now still redirects the next fetch
      old_pc    <= pc - 64'd4;
      out_valid <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== src/itlb.sv ====
`timescale 1ns/10ps
`default_nettype none

module itlb (
  input  logic                 clk,
  input  logic                 reset,
  input  fetch_pkg::xlate_t    xlate,
  input  logic [63:0]          ptbr,
  output logic [63:0]          pa,
  output logic                 pa_valid,
  output logic                 reqcyc,
  output fetch_pkg::bus_req_t  req,
  input  logic                 grant,
  input  logic                 respcyc,
  input  fetch_pkg::bus_resp_t resp
);

  typedef enum logic {tlb_idle, tlb_walk} tlb_state_e;

  tlb_state_e                          state;
  logic [fetch_pkg::tlb_entries-1:0]   valid;
  logic [fetch_pkg::vpn_w-1:0]         vpn_tab [fetch_pkg::tlb_entries];
  logic [fetch_pkg::vpn_w-1:0]         ppn_tab [fetch_pkg::tlb_entries];
  logic [fetch_pkg::tlb_idx_w-1:0]     victim;    // Round-robin pointer
  logic [fetch_pkg::vpn_w-1:0]         miss_vpn;
  logic                                sent;      // Request taken by the arbiter
  logic [fetch_pkg::vpn_w-1:0]         va_vpn;
  logic [fetch_pkg::vpn_w-1:0]         hit_ppn;
  logic                                hit;
  logic                                pte_beat;
  logic                                start_walk;

  assign va_vpn = xlate.va[fetch_pkg::addr_w-1:fetch_pkg::page_bits];

  // Fully associative match
  always_comb begin
    hit     = 1'b0;
    hit_ppn = '0;
    for (int i = 0; i < fetch_pkg::tlb_entries; i++) begin
      if (valid[i] && vpn_tab[i] == va_vpn) begin
        hit     = 1'b1;
        hit_ppn = ppn_tab[i];
      end
    end
  end

  assign pa       = {hit_ppn, xlate.va[fetch_pkg::page_bits-1:0]};
  assign pa_valid = xlate.rd && hit;

  assign start_walk = state == tlb_idle && xlate.rd && !hit;
  assign pte_beat   = grant && respcyc && resp.tag == fetch_pkg::tag_tlb;

  assign reqcyc   = state == tlb_walk && !sent && !grant;
  assign req.addr = ptbr + {9'd0, miss_vpn, 3'b000};  // Single-level walk, 8-byte PTEs
  assign req.tag  = fetch_pkg::tag_tlb;

  always_ff @(posedge clk) begin
    if (reset) begin
      state  <= tlb_idle;
      valid  <= '0;
      victim <= '0;
      sent   <= 1'b0;
    end else begin
      case (state)
        tlb_idle: begin
          if (start_walk) begin
            state <= tlb_walk;
            sent  <= 1'b0;
          end
        end
        tlb_walk: begin
          if (grant)
            sent <= 1'b1;
          if (pte_beat) begin
            valid[victim] <= 1'b1;
            victim        <= victim + 1'b1;
            state         <= tlb_idle;
          end
        end
        default: state <= tlb_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (start_walk)
      miss_vpn <= va_vpn;
    if (state == tlb_walk && pte_beat) begin
      vpn_tab[victim] <= miss_vpn;
      ppn_tab[victim] <= resp.data[fetch_pkg::addr_w-1:fetch_pkg::page_bits];
    end
  end

endmodule

`default_nettype wire

// ==== src/icache.sv ====
`timescale 1ns/10ps
`default_nettype none

module icache (
  input  logic                 clk,
  input  logic                 reset,
  input  logic [63:0]          pa,
  input  logic                 rd,
  input  logic                 pa_valid,
  output logic [31:0]          instr_bits,
  output logic                 data_valid,
  output logic                 reqcyc,
  output fetch_pkg::bus_req_t  req,
  input  logic                 grant,
  input  logic                 respcyc,
  input  fetch_pkg::bus_resp_t resp
);

  typedef enum logic {ic_idle, ic_fill} ic_state_e;

  ic_state_e                              state;
  logic [fetch_pkg::icache_lines-1:0]     valid;
  logic [fetch_pkg::ctag_w-1:0]           tags [fetch_pkg::icache_lines];
  logic [fetch_pkg::bus_data_w-1:0]       data_mem [fetch_pkg::icache_lines *
                                                    fetch_pkg::beats_per_line];
  logic [fetch_pkg::index_w-1:0]          idx;
  logic [fetch_pkg::ctag_w-1:0]           ptag;
  logic [fetch_pkg::beat_sel_w-1:0]       beat_sel;
  logic [fetch_pkg::bus_data_w-1:0]       rd_beat;
  logic                                   lookup;
  logic                                   hit;
  logic                                   start_fill;
  logic                                   line_beat;
  logic                                   sent;
  logic [fetch_pkg::beat_sel_w-1:0]       cnt;       // Beats written so far
  logic [fetch_pkg::index_w-1:0]          fill_idx;
  logic [fetch_pkg::addr_w-1:0]           fill_addr;

  assign idx      = pa[fetch_pkg::line_off_w +: fetch_pkg::index_w];
  assign ptag     = pa[fetch_pkg::addr_w-1 -: fetch_pkg::ctag_w];
  assign beat_sel = pa[fetch_pkg::byte_off_w +: fetch_pkg::beat_sel_w];

  assign lookup = rd && pa_valid;
  assign hit    = valid[idx] && tags[idx] == ptag;

  assign rd_beat    = data_mem[{idx, beat_sel}];
  assign instr_bits = pa[fetch_pkg::byte_off_w-1] ? rd_beat[63:32] : rd_beat[31:0];
  assign data_valid = lookup && hit;

  assign start_fill = state == ic_idle && lookup && !hit;
  assign line_beat  = grant && respcyc && resp.tag == fetch_pkg::tag_icache;

  assign reqcyc   = state == ic_fill && !sent && !grant;
  assign req.addr = fill_addr;
  assign req.tag  = fetch_pkg::tag_icache;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ic_idle;
      valid <= '0;
      sent  <= 1'b0;
      cnt   <= '0;
    end else begin
      case (state)
        ic_idle: begin
          if (start_fill) begin
            state      <= ic_fill;
            valid[idx] <= 1'b0;   // Line is being overwritten
            sent       <= 1'b0;
            cnt        <= '0;
          end
        end
        ic_fill: begin
          if (grant)
            sent <= 1'b1;
          if (line_beat) begin
            cnt <= cnt + 1'b1;
            if (cnt == fetch_pkg::last_beat) begin
              valid[fill_idx] <= 1'b1;
              state           <= ic_idle;
            end
          end
        end
        default: state <= ic_idle;
      endcase
    end
  end

  // Line-aligned request, beats arrive in address order
  always_ff @(posedge clk) begin
    if (start_fill) begin
      fill_idx  <= idx;
      fill_addr <= {pa[fetch_pkg::addr_w-1:fetch_pkg::line_off_w],
                    {fetch_pkg::line_off_w{1'b0}}};
      tags[idx] <= ptag;
    end
    if (state == ic_fill && line_beat)
      data_mem[{fill_idx, cnt}] <= resp.data;
  end

endmodule

`default_nettype wire

// ==== src/bus_arbiter.sv ====
`timescale 1ns/10ps
`default_nettype none

module bus_arbiter (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 tlb_reqcyc,
  input  fetch_pkg::bus_req_t  tlb_req,
  output logic                 tlb_grant,
  input  logic                 ic_reqcyc,
  input  fetch_pkg::bus_req_t  ic_req,
  output logic                 ic_grant,
  output logic                 bus_reqcyc,
  output fetch_pkg::bus_req_t  bus_req,
  input  logic                 bus_reqack,
  input  logic                 bus_respcyc,
  input  fetch_pkg::bus_resp_t bus_resp,
  output logic                 bus_respack
);

  typedef enum logic [1:0] {arb_idle, arb_req, arb_resp} arb_state_e;

  arb_state_e                       state;
  fetch_pkg::bus_tag_e              owner;
  logic [fetch_pkg::beat_sel_w-1:0] cnt;
  logic                             owner_beat;
  logic                             last;

  assign bus_reqcyc  = state == arb_req;
  assign bus_req     = owner == fetch_pkg::tag_tlb ? tlb_req : ic_req;
  assign bus_respack = bus_respcyc;   // Every beat is taken

  assign tlb_grant = state == arb_resp && owner == fetch_pkg::tag_tlb;
  assign ic_grant  = state == arb_resp && owner == fetch_pkg::tag_icache;

  assign owner_beat = bus_respcyc && bus_resp.tag == owner;
  assign last       = owner == fetch_pkg::tag_tlb || cnt == fetch_pkg::last_beat;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= arb_idle;
      owner <= fetch_pkg::tag_tlb;
      cnt   <= '0;
    end else begin
      case (state)
        arb_idle: begin
          if (tlb_reqcyc) begin        // TLB walk first
            owner <= fetch_pkg::tag_tlb;
            state <= arb_req;
          end else if (ic_reqcyc) begin
            owner <= fetch_pkg::tag_icache;
            state <= arb_req;
          end
        end
        arb_req: begin
          if (bus_reqack) begin
            state <= arb_resp;
            cnt   <= '0;
          end
        end
        arb_resp: begin
          if (owner_beat) begin
            cnt <= cnt + 1'b1;
            if (last)
              state <= arb_idle;
          end
        end
        default: state <= arb_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== src/fetch_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module fetch_top (
  input  logic                  clk,
  input  logic                  reset,
  input  logic [63:0]           entry,
  input  logic [63:0]           ptbr,
  input  logic                  branch_taken,
  input  logic [63:0]           target,
  input  logic                  enable,
  input  logic                  syscall_flush,
  input  logic [63:0]           sys_call_addrplus1,
  output fetch_pkg::fetch_out_t out,
  output logic                  out_valid,
  output logic                  bus_reqcyc,
  output fetch_pkg::bus_req_t   bus_req,
  input  logic                  bus_reqack,
  input  logic                  bus_respcyc,
  input  fetch_pkg::bus_resp_t  bus_resp,
  output logic                  bus_respack
);

  fetch_pkg::xlate_t   xlate;
  logic [63:0]         pa;
  logic                pa_valid;
  logic                cache_rd;
  logic [31:0]         instr_bits;
  logic                data_valid;
  logic                tlb_reqcyc;
  fetch_pkg::bus_req_t tlb_req;
  logic                tlb_grant;
  logic                ic_reqcyc;
  fetch_pkg::bus_req_t ic_req;
  logic                ic_grant;

  fetch u_fetch (
    .clk                (clk),
    .reset              (reset),
    .entry              (entry),
    .branch_taken       (branch_taken),
    .target             (target),
    .enable             (enable),
    .syscall_flush      (syscall_flush),
    .sys_call_addrplus1 (sys_call_addrplus1),
    .xlate              (xlate),
    .pa_valid           (pa_valid),
    .cache_rd           (cache_rd),
    .instr_bits         (instr_bits),
    .data_valid         (data_valid),
    .out                (out),
    .out_valid          (out_valid)
  );

  itlb u_itlb (
    .clk      (clk),
    .reset    (reset),
    .xlate    (xlate),
    .ptbr     (ptbr),
    .pa       (pa),
    .pa_valid (pa_valid),
    .reqcyc   (tlb_reqcyc),
    .req      (tlb_req),
    .grant    (tlb_grant),
    .respcyc  (bus_respcyc),
    .resp     (bus_resp)
  );

  icache u_icache (
    .clk        (clk),
    .reset      (reset),
    .pa         (pa),
    .rd         (cache_rd),
    .pa_valid   (pa_valid),
    .instr_bits (instr_bits),
    .data_valid (data_valid),
    .reqcyc     (ic_reqcyc),
    .req        (ic_req),
    .grant      (ic_grant),
    .respcyc    (bus_respcyc),
    .resp       (bus_resp)
  );

  bus_arbiter u_bus_arbiter (
    .clk         (clk),
    .reset       (reset),
    .tlb_reqcyc  (tlb_reqcyc),
    .tlb_req     (tlb_req),
    .tlb_grant   (tlb_grant),
    .ic_reqcyc   (ic_reqcyc),
    .ic_req      (ic_req),
    .ic_grant    (ic_grant),
    .bus_reqcyc  (bus_reqcyc),
    .bus_req     (bus_req),
    .bus_reqack  (bus_reqack),
    .bus_respcyc (bus_respcyc),
    .bus_resp    (bus_resp),
    .bus_respack (bus_respack)
  );

endmodule

`default_nettype wire

// ==== tb/fetch_chk.sv ====
`timescale 1ns/10ps
`default_nettype none

module fetch_chk (
  input logic                  clk,
  input logic                  reset,
  input logic [63:0]           entry,
  input logic                  branch_taken,
  input logic [63:0]           target,
  input logic                  enable,
  input logic                  syscall_flush,
  input logic [63:0]           sys_call_addrplus1,
  input fetch_pkg::fetch_out_t out,
  input logic                  out_valid,
  input logic                  bus_reqcyc,
  input fetch_pkg::bus_req_t   bus_req,
  input logic                  bus_reqack,
  input logic                  bus_respcyc,
  input logic                  bus_respack
);

  int          fail_count = 0;
  logic [63:0] last_pc;        // PC presented in the previous cycle
  logic [63:0] cur_pc;
  logic        seen_first;
  logic        flush_pending;
  logic [63:0] flush_addr;

  // Page number xor-ed into the physical page, then the word rule on the low half
  function automatic logic [31:0] expected_instr(input logic [63:0] va);
    logic [63:0] pa;
    pa = {va[63:fetch_pkg::page_bits] ^ fetch_pkg::ppn_xor, va[fetch_pkg::page_bits-1:0]};
    return pa[31:0] ^ fetch_pkg::instr_xor;
  endfunction

  // Flush, then branch, then the next sequential PC once the last one was delivered
  always_comb begin
    if (syscall_flush)
      cur_pc = sys_call_addrplus1 - 64'd4;
    else if (branch_taken)
      cur_pc = target;
    else if (out_valid)
      cur_pc = last_pc + 64'd4;
    else
      cur_pc = last_pc;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      last_pc       <= entry;
      seen_first    <= 1'b0;
      flush_pending <= 1'b0;
      flush_addr    <= '0;
    end else begin
      last_pc <= cur_pc;
      if (out_valid)
        seen_first <= 1'b1;
      if (syscall_flush) begin
        flush_pending <= 1'b1;
        flush_addr    <= sys_call_addrplus1;
      end else if (out_valid || branch_taken) begin
        flush_pending <= 1'b0;
      end
    end
  end

  first_pc_ok: assert property (@(posedge clk) disable iff (reset)
    out_valid && !seen_first |-> out.pcplus4 == entry + 64'd4)
    else begin
      fail_count++;
      $error("[ERROR] %0t first pcplus4 %h", $time, $sampled(out.pcplus4));
    end

  pc_order_ok: assert property (@(posedge clk) disable iff (reset)
    out_valid |-> out.pcplus4 == last_pc + 64'd4)
    else begin
      fail_count++;
      $error("[ERROR] %0t pcplus4 %h, expected %h", $time,
             $sampled(out.pcplus4), $sampled(last_pc) + 64'd4);
    end

  instr_word_ok: assert property (@(posedge clk) disable iff (reset)
    out_valid |-> out.instr == expected_instr(last_pc))
    else begin
      fail_count++;
      $error("[ERROR] %0t instr %h at pc %h", $time, $sampled(out.instr), $sampled(last_pc));
    end

  flush_clear_ok: assert property (@(posedge clk) disable iff (reset)
    syscall_flush |=> !out_valid && out == '0)
    else begin
      fail_count++;
      $error("[ERROR] %0t output not cleared after flush", $time);
    end

  flush_target_ok: assert property (@(posedge clk) disable iff (reset)
    out_valid && flush_pending |-> out.pcplus4 == flush_addr)
    else begin
      fail_count++;
      $error("[ERROR] %0t pcplus4 %h after flush to %h", $time,
             $sampled(out.pcplus4), $sampled(flush_addr));
    end

  hold_ok: assert property (@(posedge clk) disable iff (reset)
    !enable && !syscall_flush |=> !out_valid && $stable(out))
    else begin
      fail_count++;
      $error("[ERROR] %0t output moved while decode held it", $time);
    end

  reqcyc_held: assert property (@(posedge clk) disable iff (reset)
    bus_reqcyc && !bus_reqack |=> bus_reqcyc && $stable(bus_req))
    else begin
      fail_count++;
      $error("[ERROR] %0t bus request dropped or changed before reqack", $time);
    end

  respack_ok: assert property (@(posedge clk) disable iff (reset)
    bus_respack == bus_respcyc)
    else begin
      fail_count++;
      $error("[ERROR] %0t respack %b with respcyc %b", $time,
             $sampled(bus_respack), $sampled(bus_respcyc));
    end

endmodule

bind fetch_top fetch_chk u_chk (
  .clk                (clk),
  .reset              (reset),
  .entry              (entry),
  .branch_taken       (branch_taken),
  .target             (target),
  .enable             (enable),
  .syscall_flush      (syscall_flush),
  .sys_call_addrplus1 (sys_call_addrplus1),
  .out                (out),
  .out_valid          (out_valid),
  .bus_reqcyc         (bus_reqcyc),
  .bus_req            (bus_req),
  .bus_reqack         (bus_reqack),
  .bus_respcyc        (bus_respcyc),
  .bus_respack        (bus_respack)
);

`default_nettype wire

// ==== tb/fetch_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module fetch_tb;

  localparam int reset_cycles    = 16;
  localparam int seq_count       = 24;
  localparam int branch_count    = 40;
  localparam int stall_count     = 16;
  localparam int flush_count     = 3;
  localparam int cycles_per_step = 48;   // TLB walk plus line fill at worst latency, with slack
  localparam int cycle_limit     = reset_cycles + cycles_per_step *
                                   (seq_count + branch_count + stall_count + flush_count);

  logic                  clk = 1'b0;
  logic                  reset;
  logic [63:0]           entry;
  logic [63:0]           ptbr;
  logic                  branch_taken;
  logic [63:0]           target;
  logic                  enable;
  logic                  syscall_flush;
  logic [63:0]           sys_call_addrplus1;
  fetch_pkg::fetch_out_t out;
  logic                  out_valid;
  logic                  bus_reqcyc;
  fetch_pkg::bus_req_t   bus_req;
  logic                  bus_reqack;
  logic                  bus_respcyc;
  fetch_pkg::bus_resp_t  bus_resp;
  logic                  bus_respack;
  integer                seed = 32'hd86c_137a;
  int                    cycles = 0;
  int                    outputs = 0;
  logic [63:0]           page_base [4];

  fetch_top u_fetch_top (
    .clk                (clk),
    .reset              (reset),
    .entry              (entry),
    .ptbr               (ptbr),
    .branch_taken       (branch_taken),
    .target             (target),
    .enable             (enable),
    .syscall_flush      (syscall_flush),
    .sys_call_addrplus1 (sys_call_addrplus1),
    .out                (out),
    .out_valid          (out_valid),
    .bus_reqcyc         (bus_reqcyc),
    .bus_req            (bus_req),
    .bus_reqack         (bus_reqack),
    .bus_respcyc        (bus_respcyc),
    .bus_resp           (bus_resp),
    .bus_respack        (bus_respack)
  );

  always #10 clk = ~clk;

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic wait_output();
    step();
    while (!out_valid)
      step();
  endtask

  function automatic int random_span(input int n);
    return 1 + int'($unsigned($random(seed)) % n);
  endfunction

  // Word aligned PC somewhere in one of the four branch pages
  function automatic logic [63:0] random_pc();
    logic [1:0]  pg;
    logic [11:0] off;
    pg  = 2'($random(seed));
    off = 12'($random(seed)) & 12'hffc;
    return page_base[pg] | {52'd0, off};
  endfunction

  // Single level page table, one 8-byte PTE per virtual page
  function automatic logic [63:0] pte_value(input logic [63:0] addr);
    logic [63:0] vpn;
    vpn = (addr - ptbr) >> 3;
    return {vpn[51:0] ^ fetch_pkg::ppn_xor, 12'h000};
  endfunction

  function automatic logic [63:0] mem_value(input logic [63:0] addr);
    logic [31:0] lo;
    lo = {addr[31:3], 3'b000};
    return {(lo + 32'd4) ^ fetch_pkg::instr_xor, lo ^ fetch_pkg::instr_xor};
  endfunction

  task automatic pulse_branch(input logic [63:0] to);
    branch_taken = 1'b1;
    target       = to;
    step();
    branch_taken = 1'b0;
  endtask

  task automatic pulse_flush(input logic [63:0] addrplus1);
    syscall_flush      = 1'b1;
    sys_call_addrplus1 = addrplus1;
    step();
    syscall_flush = 1'b0;
  endtask

  task automatic report_counts();
    $display("Summary: %0d assertion failures, %0d outputs in %0d cycles",
             u_fetch_top.u_chk.fail_count, outputs, cycles);
  endtask

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (out_valid)
      outputs = outputs + 1;
    if (cycles >= cycle_limit) begin
      $display("Run timed out after %0d cycles without finishing the stimulus", cycles);
      report_counts();
      $display("Checks failed");
      $finish;
    end
  end

  // Memory and page table answering the bus
  initial begin : memory_model
    logic [63:0]         addr;
    fetch_pkg::bus_tag_e tag;
    int                  beats;
    bus_reqack  = 1'b0;
    bus_respcyc = 1'b0;
    bus_resp    = '0;
    forever begin
      step();
      if (!reset && bus_reqcyc) begin
        addr  = bus_req.addr;
        tag   = bus_req.tag;
        beats = tag == fetch_pkg::tag_tlb ? 1 : 4;
        repeat (random_span(3) - 1)
          step();                    // Request waits for reqack
        bus_reqack = 1'b1;
        step();
        bus_reqack = 1'b0;
        repeat (random_span(4) - 1)
          step();
        for (int k = 0; k < beats; k++) begin
          bus_respcyc   = 1'b1;
          bus_resp.tag  = tag;
          bus_resp.data = tag == fetch_pkg::tag_tlb ? pte_value(addr) :
                          mem_value(addr + 64'(8 * k));
          step();
        end
        bus_respcyc = 1'b0;
      end
    end
  end

  initial begin
    page_base[0]       = 64'h0000_0000_1000_0000;
    page_base[1]       = 64'h0000_0000_1000_1000;
    page_base[2]       = 64'h0000_0000_2000_5000;
    page_base[3]       = 64'h0000_0000_7fff_f000;
    reset              = 1'b1;
    entry              = 64'h0000_0000_0040_1fc0;   // 16 words before a page boundary
    ptbr               = 64'h0000_0000_8000_0000;
    branch_taken       = 1'b0;
    target             = '0;
    enable             = 1'b1;
    syscall_flush      = 1'b0;
    sys_call_addrplus1 = '0;
    repeat (reset_cycles) @(posedge clk);
    #1;
    reset = 1'b0;

    repeat (seq_count)
      wait_output();

    repeat (branch_count) begin
      pulse_branch(random_pc());
      repeat (random_span(3))
        wait_output();
    end

    repeat (stall_count) begin
      enable = 1'b0;
      repeat (random_span(6))
        step();
      enable = 1'b1;
      wait_output();
    end

    // First flush hits while a line fill for a fresh page is on the bus
    pulse_branch(64'h0000_0000_3000_0800);
    while (!(bus_respcyc && bus_resp.tag == fetch_pkg::tag_icache))
      step();
    pulse_flush(random_pc() + 64'd4);
    repeat (2)
      wait_output();
    repeat (flush_count - 1) begin
      pulse_flush(random_pc() + 64'd4);
      repeat (2)
        wait_output();
    end

    repeat (4)
      step();
    report_counts();
    if (u_fetch_top.u_chk.fail_count == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
src/fetch_pkg.sv
src/fetch.sv
src/itlb.sv
src/icache.sv
src/bus_arbiter.sv
src/fetch_top.sv
tb/fetch_chk.sv
tb/fetch_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= fetch_tb
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= All checks passed

SRCS := $(shell cat build.f)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): build.f $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f build.f

run: $(BIN)
	@out="$$($(BIN) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
